//--- Bender.yml
package:
  name: fix_session

export_include_dirs:
  - .

sources:
  - files:
      - fix_pkg.sv
      - session_ram.sv
      - host_addr_table.sv
      - heartbeat_timer.sv
      - session_manager.sv
      - fix_session_top.sv
  - target: test
    files:
      - fix_session_props.sv
      - fix_session_tb.sv

//--- fix_consts.svh
// width macros for the FIX session layer
// message type, validity and error codes, heartbeat interval
`ifndef FIX_CONSTS_SVH
`define FIX_CONSTS_SVH

`define HOST_W          2
`define NUM_HOSTS       (1 << `HOST_W)
`define COMP_ID_W       64
`define COMP_LEN_W      4
`define HB_INTERVAL     40 // cycles between heartbeat checks

// message types, as seen by parser and builder
`define MT_LOGON        4'd1
`define MT_LOGOUT       4'd2
`define MT_HEARTBEAT    4'd3
`define MT_RESEND_REQ   4'd4
`define MT_GAP_FILL     4'd5
`define MT_SEQ_RESET    4'd6
`define MT_APP          4'd7

// validity codes from the parser
`define VD_VALID        3'd0
`define VD_GARBLED      3'd1
`define VD_SEQ_HIGH     3'd2 // gap ahead of us
`define VD_SEQ_LOW      3'd3
`define VD_INVALID      3'd4

// disconnect reasons
`define ERR_NONE        3'd0 // clean close
`define ERR_FATAL       3'd1
`define ERR_PROTOCOL    3'd2
`define ERR_TIMEOUT     3'd3

`endif

//--- fix_pkg.sv
// types of the FIX session layer
// vector typedefs and the per-host session state encoding
`include "fix_consts.svh"

package fix_pkg;

	// host number and message fields
	typedef logic [`HOST_W-1:0]     host_t;
	typedef logic [3:0]             msg_type_t;
	typedef logic [2:0]             validity_t;
	typedef logic [2:0]             err_code_t;

	// peer identity, from the host table
	typedef logic [`COMP_ID_W-1:0]  comp_id_t;
	typedef logic [`COMP_LEN_W-1:0] comp_len_t; // valid bytes of comp id

	// session state kept per host
	typedef enum logic [2:0] {
		S_DISCONNECTED  = 3'd0,
		S_LOGON_SENT,           // waiting for peer logon
		S_NORMAL,
		S_HB_SENT,              // heartbeat out, waiting for traffic
		S_RESEND_SENT,          // gap seen, waiting for fill
		S_RESEND_LOGOUT,        // gap seen on a logout
		S_LOGOUT_SENT
	} sess_state_e;

endpackage

//--- fix_session_props.sv
// concurrent checks on the session top outputs
// bound into fix_session_top
`timescale 1ns/10ps
`include "fix_consts.svh"

module fix_session_props (
	input logic               clk,
	input logic               rst,
	input logic               msg_req_o,
	input fix_pkg::msg_type_t msg_kind_o,
	input logic               disconnect_o,
	input logic               ignore_o,
	input logic               accept_o,
	input logic               seq_update_o
);
	import fix_pkg::*;

	int   fail_cnt = 0; // failed assertions so far
	logic any_pulse;

	assign any_pulse = msg_req_o | disconnect_o | ignore_o | accept_o | seq_update_o;

	a_reset_quiet: assert property (@(posedge clk) rst |=> !any_pulse)
		else begin
			fail_cnt++;
			$error("output pulse during or right after reset");
		end

	a_pulses_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({msg_req_o, disconnect_o, ignore_o, accept_o, seq_update_o}))
		else begin
			fail_cnt++;
			$error("unknown output pulse");
		end

	// builder only knows these kinds
	a_kind_known: assert property (@(posedge clk) disable iff (rst)
		msg_req_o |-> !$isunknown(msg_kind_o) && (msg_kind_o inside {`MT_LOGON, `MT_LOGOUT,
		`MT_HEARTBEAT, `MT_RESEND_REQ, `MT_GAP_FILL}))
		else begin
			fail_cnt++;
			$error("message request with unknown kind %0d", msg_kind_o);
		end

	a_disc_not_acc: assert property (@(posedge clk) disable iff (rst)
		!(disconnect_o && accept_o))
		else begin
			fail_cnt++;
			$error("disconnect and accept in the same cycle");
		end

endmodule

bind fix_session_top fix_session_props props_i (
	.clk          (clk),
	.rst          (rst),
	.msg_req_o    (msg_req_o),
	.msg_kind_o   (msg_kind_o),
	.disconnect_o (disconnect_o),
	.ignore_o     (ignore_o),
	.accept_o     (accept_o),
	.seq_update_o (seq_update_o)
);

//--- fix_session_tb.sv
// testbench for the FIX session layer top
// per-host reference model, in-order compare two cycles after each event
// directed and random phases, heartbeat timeout phase, watchdog
`timescale 1ns/10ps
`include "fix_consts.svh"

module fix_session_tb;
	import fix_pkg::*;

	localparam int         N_RAND    = 300;
	localparam int         N_EVENTS  = N_RAND + 64;
	localparam int         QUIET     = `HB_INTERVAL + 8; // one full heartbeat round
	localparam int         WD_CYCLES = N_EVENTS * 3 + 4 * `HB_INTERVAL + 200;
	localparam logic [2:0] EV_IDLE   = 3'd0;
	localparam logic [2:0] EV_MSG    = 3'd1;
	localparam logic [2:0] EV_CONN   = 3'd2;
	localparam logic [2:0] EV_END    = 3'd3;
	localparam logic [2:0] EV_TO     = 3'd4;

	typedef struct packed {
		sess_state_e nxt;
		logic        req;
		msg_type_t   kind;
		logic        disc;
		err_code_t   err;
		logic        ign;
		logic        acc;
		logic        seq;
	} resp_t;

	typedef struct packed {
		logic [2:0] ev;
		host_t      host;
		msg_type_t  mtype;
		validity_t  vld;
	} slot_t;

	logic      clk;
	logic      rst;
	logic      new_msg_i;
	logic      connect_i;
	logic      end_session_i;
	host_t     host_i;
	msg_type_t msg_type_i;
	validity_t validity_i;
	logic      cfg_we_i;
	host_t     cfg_host_i;
	comp_id_t  cfg_comp_id_i;
	comp_len_t cfg_comp_len_i;
	logic      msg_req_o;
	msg_type_t msg_kind_o;
	comp_id_t  target_comp_id_o;
	comp_len_t target_len_o;
	logic      disconnect_o;
	host_t     disconnect_host_o;
	err_code_t error_o;
	logic      ignore_o;
	logic      accept_o;
	logic      seq_update_o;
	host_t     seq_host_o;

	comp_id_t              cfg_id  [`NUM_HOSTS];
	comp_len_t             cfg_len [`NUM_HOSTS];
	sess_state_e           model   [`NUM_HOSTS];
	int                    hb_seen [`NUM_HOSTS]; // heartbeats caused by timeouts
	int                    to_seen [`NUM_HOSTS]; // timeout disconnects
	logic [`NUM_HOSTS-1:0] watch;
	slot_t                 slots [$];
	host_t                 last_host;

	fix_session_top fix_session_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog");
	end

	task automatic report_mismatch(string what);
		$display("ERR %0t %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_flags(logic req, logic disc, logic ign, logic acc, logic seq,
			host_t shost);
		logic [4:0] got;
		logic [4:0] want;
		got  = {msg_req_o, disconnect_o, ignore_o, accept_o, seq_update_o};
		want = {req, disc, ign, acc, seq};
		if (got !== want)
			report_mismatch($sformatf("host %0d req,disc,ign,acc,seq %b, expected %b",
				shost, got, want));
		else if (seq && seq_host_o !== shost)
			report_mismatch($sformatf("seq_host_o %0d, expected %0d", seq_host_o, shost));
	endtask

	task automatic check_req(msg_type_t kind, comp_id_t id, comp_len_t len);
		if (msg_kind_o !== kind || target_comp_id_o !== id || target_len_o !== len)
			report_mismatch($sformatf("request kind %0d id %h len %0d, expected %0d %h %0d",
				msg_kind_o, target_comp_id_o, target_len_o, kind, id, len));
	endtask

	task automatic check_disc(host_t h, err_code_t err);
		if (disconnect_host_o !== h || error_o !== err)
			report_mismatch($sformatf("disconnect host %0d err %0d, expected %0d %0d",
				disconnect_host_o, error_o, h, err));
	endtask

	// expected response of one session to one event
	function automatic resp_t next_response(sess_state_e st, logic [2:0] ev, msg_type_t mt,
			validity_t vd);
		resp_t r;
		logic  fatal;
		logic  high;
		fatal  = (vd == `VD_SEQ_LOW) || (vd == `VD_INVALID);
		high   = (vd == `VD_SEQ_HIGH);
		r.nxt  = st;
		r.req  = 1'b0;
		r.kind = `MT_HEARTBEAT;
		r.disc = 1'b0;
		r.err  = `ERR_NONE;
		r.ign  = 1'b0;
		r.acc  = 1'b0;
		r.seq  = 1'b0;
		case (ev)
			EV_CONN: begin
				r.req  = 1'b1;
				r.kind = `MT_LOGON;
				r.nxt  = S_LOGON_SENT;
			end
			EV_END: begin
				if (st == S_NORMAL || st == S_HB_SENT) begin
					r.req  = 1'b1;
					r.kind = `MT_LOGOUT;
					r.nxt  = S_LOGOUT_SENT;
				end
			end
			EV_TO: begin
				case (st)
					S_NORMAL: begin
						r.req = 1'b1;
						r.nxt = S_HB_SENT;
					end
					S_RESEND_SENT, S_RESEND_LOGOUT: r.req = 1'b1;
					S_LOGON_SENT, S_LOGOUT_SENT, S_HB_SENT: begin
						r.disc = 1'b1;
						r.err  = `ERR_TIMEOUT;
						r.nxt  = S_DISCONNECTED;
					end
					default: r.nxt = st;
				endcase
			end
			EV_MSG: begin
				if (fatal) begin
					r.disc = 1'b1;
					r.err  = `ERR_FATAL;
					r.nxt  = S_DISCONNECTED;
				end else if (st == S_DISCONNECTED) begin
					r.ign = 1'b1;
				end else if (st == S_LOGON_SENT) begin
					if (mt == `MT_LOGON && vd == `VD_VALID) begin
						r.acc = 1'b1;
						r.nxt = S_NORMAL;
					end else if (mt == `MT_LOGON && high) begin
						r.req  = 1'b1;
						r.kind = `MT_RESEND_REQ;
						r.nxt  = S_RESEND_SENT;
					end else begin
						r.disc = 1'b1;
						r.err  = `ERR_PROTOCOL;
						r.nxt  = S_DISCONNECTED;
					end
				end else if (vd == `VD_GARBLED) begin
					r.ign = 1'b1;
				end else if (st == S_LOGOUT_SENT) begin
					r.disc = 1'b1;
					r.err  = (mt == `MT_LOGOUT) ? `ERR_NONE : `ERR_PROTOCOL;
					r.nxt  = S_DISCONNECTED;
				end else if (st == S_RESEND_SENT || st == S_RESEND_LOGOUT) begin
					if (mt == `MT_GAP_FILL || mt == `MT_SEQ_RESET) begin
						r.seq = 1'b1;
						r.nxt = S_NORMAL;
						if (st == S_RESEND_LOGOUT) begin
							r.req  = 1'b1; // logout held back by the gap
							r.kind = `MT_LOGOUT;
							r.nxt  = S_LOGOUT_SENT;
						end
					end else if (high) begin
						r.req  = 1'b1;
						r.kind = `MT_RESEND_REQ;
					end else begin
						r.acc = 1'b1;
					end
				end else if (mt == `MT_LOGOUT) begin
					r.req  = 1'b1;
					r.kind = high ? `MT_RESEND_REQ : `MT_LOGOUT;
					r.disc = !high;
					r.nxt  = high ? S_RESEND_LOGOUT : S_DISCONNECTED;
				end else if (mt == `MT_RESEND_REQ) begin
					r.req  = 1'b1;
					r.kind = `MT_GAP_FILL;
				end else if (high) begin
					r.req  = 1'b1;
					r.kind = `MT_RESEND_REQ;
					r.nxt  = S_RESEND_SENT;
				end else begin
					r.req = (mt == `MT_HEARTBEAT);
					r.acc = (mt != `MT_HEARTBEAT);
					r.nxt = S_NORMAL;
				end
			end
			default: r.nxt = st;
		endcase
		return r;
	endfunction

	function automatic slot_t sample_slot();
		slot_t s;
		s.ev    = new_msg_i ? EV_MSG : connect_i ? EV_CONN : end_session_i ? EV_END : EV_IDLE;
		s.host  = host_i;
		s.mtype = msg_type_i;
		s.vld   = validity_i;
		return s;
	endfunction

	task automatic compare_slot(slot_t s);
		resp_t      r;
		host_t      h;
		logic [2:0] ev;
		logic       hit;
		ev  = s.ev;
		h   = s.host;
		hit = 1'b0;
		if (ev == EV_IDLE) begin
			// only a taken timeout answers in a cycle without an event
			if ({msg_req_o, disconnect_o, ignore_o, accept_o, seq_update_o} === 5'b0)
				return;
			ev = EV_TO;
			if (disconnect_o === 1'b1) begin
				h   = disconnect_host_o;
				hit = 1'b1;
			end else if (msg_req_o === 1'b1) begin
				for (int i = 0; i < `NUM_HOSTS; i++) begin
					if (target_comp_id_o === cfg_id[i]) begin
						h   = host_t'(i); // comp ids are unique per host
						hit = 1'b1;
					end
				end
			end
			if (!hit)
				report_mismatch("output pulse in a cycle with no event and no timeout host");
		end
		r = next_response(model[h], ev, s.mtype, s.vld);
		check_flags(r.req, r.disc, r.ign, r.acc, r.seq, h);
		if (r.req)
			check_req(r.kind, cfg_id[h], cfg_len[h]);
		if (r.disc)
			check_disc(h, r.err);
		model[h] = r.nxt;
		if (ev == EV_TO) begin
			hb_seen[h] += int'(r.req);
			to_seen[h] += int'(r.disc);
		end
	endtask

	always @(posedge clk) begin
		if (!rst)
			slots.push_back(sample_slot());
	end

	// outputs of the event sampled two falling edges ago
	always @(negedge clk) begin
		if (slots.size() >= 2)
			compare_slot(slots.pop_front());
	end

	task automatic drive(logic [2:0] ev, host_t h, msg_type_t mt, validity_t vd);
		@(negedge clk);
		new_msg_i     = (ev == EV_MSG);
		connect_i     = (ev == EV_CONN);
		end_session_i = (ev == EV_END);
		host_i        = h;
		msg_type_i    = mt;
		validity_i    = vd;
	endtask

	task automatic write_table(host_t h);
		comp_id_t id;
		id = {$urandom, $urandom};
		id[`HOST_W-1:0] = h;
		@(negedge clk);
		cfg_we_i       = 1'b1;
		cfg_host_i     = h;
		cfg_comp_id_i  = id;
		cfg_comp_len_i = comp_len_t'($urandom_range(1, 15));
		cfg_id[h]      = id;
		cfg_len[h]     = cfg_comp_len_i;
	endtask

	function automatic validity_t pick_validity();
		int v;
		v = $urandom_range(0, 99);
		if (v < 60)
			return `VD_VALID;
		else if (v < 78)
			return `VD_SEQ_HIGH;
		else if (v < 88)
			return `VD_GARBLED;
		else if (v < 94)
			return `VD_SEQ_LOW;
		else
			return `VD_INVALID;
	endfunction

	task automatic random_event();
		int        pick;
		host_t     h;
		msg_type_t mt;
		validity_t vd;
		pick = $urandom_range(0, 99);
		h    = ($urandom_range(0, 1) == 0) ? last_host : host_t'($urandom_range(0, 3));
		mt   = msg_type_t'($urandom_range(1, 7));
		vd   = pick_validity();
		if (pick < 8)
			drive(EV_CONN, h, mt, vd); // brings dropped hosts back
		else if (pick < 12)
			drive(EV_END, h, mt, vd);
		else if (pick < 18)
			drive(EV_IDLE, h, mt, vd);
		else
			drive(EV_MSG, h, mt, vd);
		last_host = h;
	endtask

	task automatic check_quiet_round(int hb_want, int to_want);
		@(posedge clk);
		for (int h = 0; h < `NUM_HOSTS; h++) begin
			if (watch[h] && (hb_seen[h] != hb_want || to_seen[h] != to_want))
				report_mismatch($sformatf("host %0d saw %0d heartbeats %0d timeouts, want %0d %0d",
					h, hb_seen[h], to_seen[h], hb_want, to_want));
		end
	endtask

	initial begin
		void'($urandom(93651));
		rst            = 1'b1;
		new_msg_i      = 1'b0;
		connect_i      = 1'b0;
		end_session_i  = 1'b0;
		host_i         = '0;
		msg_type_i     = '0;
		validity_i     = '0;
		cfg_we_i       = 1'b0;
		cfg_host_i     = '0;
		cfg_comp_id_i  = '0;
		cfg_comp_len_i = '0;
		last_host      = '0;
		watch          = '0;
		for (int h = 0; h < `NUM_HOSTS; h++) begin
			model[h]   = S_DISCONNECTED;
			hb_seen[h] = 0;
			to_seen[h] = 0;
		end
		repeat (8) @(negedge clk);
		rst = 1'b0;

		for (int h = 0; h < `NUM_HOSTS; h++)
			write_table(host_t'(h));
		@(negedge clk);
		cfg_we_i = 1'b0;

		// logon of every host
		for (int h = 0; h < `NUM_HOSTS; h++)
			drive(EV_CONN, host_t'(h), '0, `VD_VALID);
		for (int h = 0; h < `NUM_HOSTS; h++)
			drive(EV_MSG, host_t'(h), `MT_LOGON, `VD_VALID);

		// gap handling back to back on one host
		drive(EV_MSG, 2'd0, `MT_APP, `VD_SEQ_HIGH);
		drive(EV_MSG, 2'd0, `MT_GAP_FILL, `VD_VALID);
		drive(EV_MSG, 2'd1, `MT_LOGOUT, `VD_SEQ_HIGH);
		drive(EV_MSG, 2'd1, `MT_GAP_FILL, `VD_VALID);
		drive(EV_MSG, 2'd1, `MT_LOGOUT, `VD_VALID);
		drive(EV_MSG, 2'd2, `MT_APP, `VD_SEQ_LOW);
		drive(EV_MSG, 2'd3, `MT_HEARTBEAT, `VD_INVALID);

		repeat (N_RAND)
			random_event();

		// last disconnect reaches the timer before the new connects
		repeat (2)
			drive(EV_IDLE, '0, '0, `VD_VALID);

		// fresh sessions and then silence
		for (int h = 0; h < `NUM_HOSTS; h++)
			drive(EV_CONN, host_t'(h), '0, `VD_VALID);
		for (int h = 0; h < `NUM_HOSTS; h++)
			drive(EV_MSG, host_t'(h), `MT_LOGON, `VD_VALID);
		repeat (3)
			drive(EV_IDLE, '0, '0, `VD_VALID);
		@(posedge clk);
		for (int h = 0; h < `NUM_HOSTS; h++) begin
			watch[h]   = (model[h] == S_NORMAL);
			hb_seen[h] = 0;
			to_seen[h] = 0;
		end
		repeat (QUIET) @(negedge clk);
		check_quiet_round(1, 0);
		repeat (QUIET) @(negedge clk);
		check_quiet_round(1, 1);

		// orderly close
		drive(EV_CONN, 2'd2, '0, `VD_VALID);
		drive(EV_MSG, 2'd2, `MT_LOGON, `VD_VALID);
		drive(EV_END, 2'd2, '0, `VD_VALID);
		drive(EV_MSG, 2'd2, `MT_LOGOUT, `VD_VALID);
		repeat (4)
			drive(EV_IDLE, '0, '0, `VD_VALID);
		@(posedge clk);

		if (fix_session_top_i.props_i.fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "bound assertions failed");
		end
	end

endmodule

//--- fix_session_top.sv
// FIX session layer top
// heartbeat timer, session manager, session state RAM, host address table
`timescale 1ns/10ps

module fix_session_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               new_msg_i,
	input  logic               connect_i,
	input  logic               end_session_i,
	input  fix_pkg::host_t     host_i,
	input  fix_pkg::msg_type_t msg_type_i,
	input  fix_pkg::validity_t validity_i,
	input  logic               cfg_we_i,
	input  fix_pkg::host_t     cfg_host_i,
	input  fix_pkg::comp_id_t  cfg_comp_id_i,
	input  fix_pkg::comp_len_t cfg_comp_len_i,
	output logic               msg_req_o,
	output fix_pkg::msg_type_t msg_kind_o,
	output fix_pkg::comp_id_t  target_comp_id_o,
	output fix_pkg::comp_len_t target_len_o,
	output logic               disconnect_o,
	output fix_pkg::host_t     disconnect_host_o,
	output fix_pkg::err_code_t error_o,
	output logic               ignore_o,
	output logic               accept_o,
	output logic               seq_update_o,
	output fix_pkg::host_t     seq_host_o
);
	import fix_pkg::*;

	logic        timeout;
	host_t       timeout_host;
	logic        timeout_ack;
	logic        ram_we;
	host_t       ram_addr;
	sess_state_e ram_wdata;
	sess_state_e ram_rdata;
	host_t       tbl_addr;
	comp_id_t    tbl_id;
	comp_len_t   tbl_len;

	// disconnects feed back to disarm the host's timer
	heartbeat_timer heartbeat_timer_i (
		.clk               (clk),
		.rst               (rst),
		.new_msg_i         (new_msg_i),
		.connect_i         (connect_i),
		.host_i            (host_i),
		.disconnect_i      (disconnect_o),
		.disconnect_host_i (disconnect_host_o),
		.timeout_ack_i     (timeout_ack),
		.timeout_o         (timeout),
		.timeout_host_o    (timeout_host)
	);

	session_manager session_manager_i (
		.clk               (clk),
		.rst               (rst),
		.new_msg_i         (new_msg_i),
		.connect_i         (connect_i),
		.end_session_i     (end_session_i),
		.host_i            (host_i),
		.msg_type_i        (msg_type_i),
		.validity_i        (validity_i),
		.timeout_i         (timeout),
		.timeout_host_i    (timeout_host),
		.timeout_ack_o     (timeout_ack),
		.ram_we_o          (ram_we),
		.ram_addr_o        (ram_addr),
		.ram_wdata_o       (ram_wdata),
		.ram_rdata_i       (ram_rdata),
		.tbl_addr_o        (tbl_addr),
		.tbl_id_i          (tbl_id),
		.tbl_len_i         (tbl_len),
		.msg_req_o         (msg_req_o),
		.msg_kind_o        (msg_kind_o),
		.target_comp_id_o  (target_comp_id_o),
		.target_len_o      (target_len_o),
		.disconnect_o      (disconnect_o),
		.disconnect_host_o (disconnect_host_o),
		.error_o           (error_o),
		.ignore_o          (ignore_o),
		.accept_o          (accept_o),
		.seq_update_o      (seq_update_o),
		.seq_host_o        (seq_host_o)
	);

	session_ram session_ram_i (
		.clk     (clk),
		.we_i    (ram_we),
		.addr_i  (ram_addr),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	host_addr_table host_addr_table_i (
		.clk            (clk),
		.cfg_we_i       (cfg_we_i),
		.cfg_host_i     (cfg_host_i),
		.cfg_comp_id_i  (cfg_comp_id_i),
		.cfg_comp_len_i (cfg_comp_len_i),
		.rd_addr_i      (tbl_addr),
		.rd_id_o        (tbl_id),
		.rd_len_o       (tbl_len)
	);

endmodule

//--- heartbeat_timer.sv
// heartbeat timer, one down counter per host
// armed by connect, reloaded by traffic and by a taken timeout
// pending timeouts held and offered lowest host first
`timescale 1ns/10ps
`include "fix_consts.svh"

module heartbeat_timer (
	input  logic           clk,
	input  logic           rst,
	input  logic           new_msg_i,
	input  logic           connect_i,
	input  fix_pkg::host_t host_i,
	input  logic           disconnect_i,
	input  fix_pkg::host_t disconnect_host_i,
	input  logic           timeout_ack_i,
	output logic           timeout_o,
	output fix_pkg::host_t timeout_host_o
);
	import fix_pkg::*;

	localparam int               CNT_W  = $clog2(`HB_INTERVAL + 1);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`HB_INTERVAL);

	logic [CNT_W-1:0]      cnt [`NUM_HOSTS];
	logic [`NUM_HOSTS-1:0] armed;
	logic [`NUM_HOSTS-1:0] pending;

	// priority pick, lowest host wins
	always_comb begin
		timeout_o      = |pending;
		timeout_host_o = '0;
		for (int h = `NUM_HOSTS - 1; h >= 0; h--) begin
			if (pending[h])
				timeout_host_o = host_t'(h);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			armed   <= '0;
			pending <= '0;
			for (int h = 0; h < `NUM_HOSTS; h++)
				cnt[h] <= '0;
		end else begin
			for (int h = 0; h < `NUM_HOSTS; h++) begin
				if (connect_i && host_i == host_t'(h)) begin
					armed[h]   <= 1'b1; // new session, start fresh
					pending[h] <= 1'b0;
					cnt[h]     <= RELOAD;
				end else if (disconnect_i && disconnect_host_i == host_t'(h)) begin
					armed[h]   <= 1'b0;
					pending[h] <= 1'b0; // drop any timeout not yet taken
				end else if (timeout_ack_i && timeout_host_o == host_t'(h)) begin
					pending[h] <= 1'b0;
					cnt[h]     <= RELOAD;
				end else if (new_msg_i && host_i == host_t'(h)) begin
					cnt[h] <= RELOAD; // peer traffic restarts the interval
				end else if (armed[h] && !pending[h]) begin
					if (cnt[h] == '0)
						pending[h] <= 1'b1; // hold until the manager takes it
					else
						cnt[h] <= cnt[h] - 1'b1;
				end
			end
		end
	end

endmodule

//--- host_addr_table.sv
// host address table
// target comp id and its length per host
// written from configuration, registered read port for the session manager
`timescale 1ns/10ps
`include "fix_consts.svh"

module host_addr_table (
	input  logic               clk,
	input  logic               cfg_we_i,
	input  fix_pkg::host_t     cfg_host_i,
	input  fix_pkg::comp_id_t  cfg_comp_id_i,
	input  fix_pkg::comp_len_t cfg_comp_len_i,
	input  fix_pkg::host_t     rd_addr_i,
	output fix_pkg::comp_id_t  rd_id_o,
	output fix_pkg::comp_len_t rd_len_o
);
	import fix_pkg::*;

	comp_id_t  id_mem  [`NUM_HOSTS];
	comp_len_t len_mem [`NUM_HOSTS];

	// configuration side
	always_ff @(posedge clk) begin
		if (cfg_we_i) begin
			id_mem[cfg_host_i]  <= cfg_comp_id_i;
			len_mem[cfg_host_i] <= cfg_comp_len_i;
		end
	end

	// lookup for message requests, one cycle
	always_ff @(posedge clk) begin
		rd_id_o  <= id_mem[rd_addr_i];
		rd_len_o <= len_mem[rd_addr_i];
	end

endmodule

//--- session_manager.sv
// session manager: event capture, timeout taken only when no external event
// per-host state decision with same-host bypass
// registered message request, disconnect, ignore, accept and sequence outputs
`timescale 1ns/10ps
`include "fix_consts.svh"

module session_manager (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 new_msg_i,
	input  logic                 connect_i,
	input  logic                 end_session_i,
	input  fix_pkg::host_t       host_i,
	input  fix_pkg::msg_type_t   msg_type_i,
	input  fix_pkg::validity_t   validity_i,
	input  logic                 timeout_i,
	input  fix_pkg::host_t       timeout_host_i,
	output logic                 timeout_ack_o,
	output logic                 ram_we_o,
	output fix_pkg::host_t       ram_addr_o,
	output fix_pkg::sess_state_e ram_wdata_o,
	input  fix_pkg::sess_state_e ram_rdata_i,
	output fix_pkg::host_t       tbl_addr_o,
	input  fix_pkg::comp_id_t    tbl_id_i,
	input  fix_pkg::comp_len_t   tbl_len_i,
	output logic                 msg_req_o,
	output fix_pkg::msg_type_t   msg_kind_o,
	output fix_pkg::comp_id_t    target_comp_id_o,
	output fix_pkg::comp_len_t   target_len_o,
	output logic                 disconnect_o,
	output fix_pkg::host_t       disconnect_host_o,
	output fix_pkg::err_code_t   error_o,
	output logic                 ignore_o,
	output logic                 accept_o,
	output logic                 seq_update_o,
	output fix_pkg::host_t       seq_host_o
);
	import fix_pkg::*;

	logic                  ext_ev;
	logic                  cap_valid;
	host_t                 cap_host;
	logic                  s1_msg;
	logic                  s1_conn;
	logic                  s1_end;
	logic                  s1_to;
	logic                  s1_valid;
	host_t                 s1_host;
	msg_type_t             s1_type;
	validity_t             s1_vld;
	logic                  s1_known; // host written since reset
	logic                  s1_fwd;   // same host as the event decided last
	logic [`NUM_HOSTS-1:0] written;
	sess_state_e           fwd_state;
	sess_state_e           cur_state;
	sess_state_e           nxt_state;
	logic                  req_d;
	msg_type_t             kind_d;
	logic                  disc_d;
	err_code_t             err_d;
	logic                  ign_d;
	logic                  acc_d;
	logic                  seq_d;

	assign ext_ev        = new_msg_i | connect_i | end_session_i;
	assign timeout_ack_o = timeout_i & ~ext_ev; // timer keeps it pending otherwise
	assign cap_valid     = ext_ev | timeout_i;
	assign cap_host      = ext_ev ? host_i : timeout_host_i;
	assign ram_addr_o    = cap_host;
	assign tbl_addr_o    = cap_host;

	// stage one, capture
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_msg  <= 1'b0;
			s1_conn <= 1'b0;
			s1_end  <= 1'b0;
			s1_to   <= 1'b0;
			s1_fwd  <= 1'b0;
			written <= '0;
		end else begin
			s1_msg  <= new_msg_i;
			s1_conn <= connect_i;
			s1_end  <= end_session_i;
			s1_to   <= timeout_ack_o;
			s1_fwd  <= cap_valid && s1_valid && s1_host == cap_host;
			if (s1_valid)
				written[s1_host] <= 1'b1; // RAM entry now holds real state
		end
		s1_host  <= cap_host;
		s1_type  <= msg_type_i;
		s1_vld   <= validity_i;
		s1_known <= written[cap_host];
	end

	assign s1_valid  = s1_msg | s1_conn | s1_end | s1_to;
	assign cur_state = s1_fwd ? fwd_state : (s1_known ? ram_rdata_i : S_DISCONNECTED);
	assign ram_we_o    = s1_valid;
	assign ram_wdata_o = nxt_state;

	// stage two, transition rules
	always_comb begin
		nxt_state = cur_state;
		req_d     = 1'b0;
		kind_d    = `MT_HEARTBEAT;
		disc_d    = 1'b0;
		err_d     = `ERR_NONE;
		ign_d     = 1'b0;
		acc_d     = 1'b0;
		seq_d     = 1'b0;
		if (s1_conn) begin
			req_d     = 1'b1;
			kind_d    = `MT_LOGON;
			nxt_state = S_LOGON_SENT;
		end else if (s1_end) begin
			if (cur_state == S_NORMAL || cur_state == S_HB_SENT) begin
				req_d     = 1'b1;
				kind_d    = `MT_LOGOUT;
				nxt_state = S_LOGOUT_SENT;
			end
		end else if (s1_to) begin
			case (cur_state)
				S_LOGON_SENT, S_LOGOUT_SENT, S_HB_SENT: begin
					disc_d    = 1'b1;
					err_d     = `ERR_TIMEOUT;
					nxt_state = S_DISCONNECTED;
				end
				S_NORMAL: begin
					req_d     = 1'b1; // heartbeat
					nxt_state = S_HB_SENT;
				end
				S_RESEND_SENT, S_RESEND_LOGOUT: req_d = 1'b1;
				default: nxt_state = cur_state; // nothing to keep alive
			endcase
		end else if (s1_msg) begin
			if (s1_vld == `VD_SEQ_LOW || s1_vld == `VD_INVALID) begin
				disc_d    = 1'b1;
				err_d     = `ERR_FATAL;
				nxt_state = S_DISCONNECTED;
			end else if (cur_state == S_DISCONNECTED) begin
				ign_d = 1'b1;
			end else if (cur_state == S_LOGON_SENT) begin
				if (s1_type == `MT_LOGON && s1_vld == `VD_VALID) begin
					acc_d     = 1'b1;
					nxt_state = S_NORMAL;
				end else if (s1_type == `MT_LOGON && s1_vld == `VD_SEQ_HIGH) begin
					req_d     = 1'b1;
					kind_d    = `MT_RESEND_REQ;
					nxt_state = S_RESEND_SENT;
				end else begin
					disc_d    = 1'b1;
					err_d     = `ERR_PROTOCOL;
					nxt_state = S_DISCONNECTED;
				end
			end else if (s1_vld == `VD_GARBLED) begin
				ign_d = 1'b1;
			end else begin
				// only valid or seq-high from here on
				case (cur_state)
					S_NORMAL, S_HB_SENT: begin
						if (s1_type == `MT_LOGOUT && s1_vld == `VD_VALID) begin
							req_d     = 1'b1;
							kind_d    = `MT_LOGOUT;
							disc_d    = 1'b1;
							nxt_state = S_DISCONNECTED;
						end else if (s1_type == `MT_LOGOUT) begin
							req_d     = 1'b1;
							kind_d    = `MT_RESEND_REQ;
							nxt_state = S_RESEND_LOGOUT;
						end else if (s1_type == `MT_RESEND_REQ) begin
							req_d  = 1'b1; // answered by a single gap fill
							kind_d = `MT_GAP_FILL;
						end else if (s1_vld == `VD_SEQ_HIGH) begin
							req_d     = 1'b1;
							kind_d    = `MT_RESEND_REQ;
							nxt_state = S_RESEND_SENT;
						end else if (s1_type == `MT_HEARTBEAT) begin
							req_d     = 1'b1;
							nxt_state = S_NORMAL;
						end else begin
							acc_d     = 1'b1;
							nxt_state = S_NORMAL;
						end
					end
					S_RESEND_SENT, S_RESEND_LOGOUT: begin
						if (s1_type == `MT_GAP_FILL || s1_type == `MT_SEQ_RESET) begin
							seq_d = 1'b1;
							if (cur_state == S_RESEND_LOGOUT) begin
								req_d     = 1'b1; // finish the deferred logout
								kind_d    = `MT_LOGOUT;
								nxt_state = S_LOGOUT_SENT;
							end else begin
								nxt_state = S_NORMAL;
							end
						end else if (s1_vld == `VD_SEQ_HIGH) begin
							req_d  = 1'b1;
							kind_d = `MT_RESEND_REQ;
						end else begin
							acc_d = 1'b1;
						end
					end
					default: begin
						disc_d    = 1'b1; // logout sent, session ends either way
						err_d     = (s1_type == `MT_LOGOUT) ? `ERR_NONE : `ERR_PROTOCOL;
						nxt_state = S_DISCONNECTED;
					end
				endcase
			end
		end
	end

	// stage two, registered outputs
	always_ff @(posedge clk) begin
		if (rst) begin
			msg_req_o    <= 1'b0;
			disconnect_o <= 1'b0;
			ignore_o     <= 1'b0;
			accept_o     <= 1'b0;
			seq_update_o <= 1'b0;
		end else begin
			msg_req_o    <= req_d;
			disconnect_o <= disc_d;
			ignore_o     <= ign_d;
			accept_o     <= acc_d;
			seq_update_o <= seq_d;
		end
		fwd_state <= nxt_state;
		if (req_d) begin
			msg_kind_o       <= kind_d;
			target_comp_id_o <= tbl_id_i;
			target_len_o     <= tbl_len_i;
		end
		if (disc_d) begin
			disconnect_host_o <= s1_host;
			error_o           <= err_d;
		end
		if (seq_d)
			seq_host_o <= s1_host;
	end

endmodule

//--- session_ram.sv
// session state memory, one entry per host
// registered read, write goes to the address of the previous cycle
`timescale 1ns/10ps
`include "fix_consts.svh"

module session_ram (
	input  logic                 clk,
	input  logic                 we_i,
	input  fix_pkg::host_t       addr_i,
	input  fix_pkg::sess_state_e wdata_i,
	output fix_pkg::sess_state_e rdata_o
);
	import fix_pkg::*;

	sess_state_e mem [`NUM_HOSTS];
	host_t       addr_q; // address read last cycle, target of the write

	// read-modify-write port, read returns the old entry on a clash
	always_ff @(posedge clk) begin
		addr_q  <= addr_i;
		rdata_o <= mem[addr_i];
		if (we_i)
			mem[addr_q] <= wdata_i;
	end

endmodule

//--- tb.f
+incdir+.
fix_pkg.sv
session_ram.sv
host_addr_table.sv
heartbeat_timer.sv
session_manager.sv
fix_session_top.sv
fix_session_props.sv
fix_session_tb.sv
